// File: verilog/non_pfr_pkg.sv
package non_pfr_pkg;

    //////////////////////////////
    // AXI4-Lite geometry
    //////////////////////////////

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Register map, byte addresses
    localparam logic [AXIL_ADDR_W-1:0] GLOBAL_STATE_ADDR  = 4'h0;
    localparam logic [7:0]             GLOBAL_STATE_RESET = 8'hDC;

    //////////////////////////////
    // LED side
    //////////////////////////////

    typedef logic [7:0] led_byte_t;

    // Segment a in bit 0 up to segment g in bit 6, driven low to light
    typedef logic [6:0] seg_glyph_t;

    // Green LEDs on bits 0 to 3 held low, amber LEDs on bits 4 to 7 held high
    localparam led_byte_t POSTLED_PATTERN = 8'hF0;

    typedef struct packed {
        logic seg1_sel_n;
        logic seg2_sel_n;
        logic postled_sel;
    } post_sel_t;

    //////////////////////////////
    // AXI4-Lite channel bundles
    //////////////////////////////

    // Master to slave
    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

// File: verilog/seven_seg_decoder.sv
`timescale 1ns/1ps

module seven_seg_decoder import non_pfr_pkg::*; (
    input  logic [3:0] i_nibble,
    output seg_glyph_t o_glyph
);

    // Bit order gfedcba, a zero lights the segment
    always_comb begin
        case (i_nibble)
            4'h0:    o_glyph = 7'b1000000;
            4'h1:    o_glyph = 7'b1111001;
            4'h2:    o_glyph = 7'b0100100;
            4'h3:    o_glyph = 7'b0110000;
            4'h4:    o_glyph = 7'b0011001;
            4'h5:    o_glyph = 7'b0010010;
            4'h6:    o_glyph = 7'b0000010;
            4'h7:    o_glyph = 7'b1111000;
            4'h8:    o_glyph = 7'b0000000;
            4'h9:    o_glyph = 7'b0011000;
            // Letters, b and d in lower case so they differ from 8 and 0
            4'hA:    o_glyph = 7'b0001000;
            4'hB:    o_glyph = 7'b0000011;
            4'hC:    o_glyph = 7'b1000110;
            4'hD:    o_glyph = 7'b0100001;
            4'hE:    o_glyph = 7'b0000110;
            default: o_glyph = 7'b0001110;
        endcase
    end

endmodule

// File: verilog/post_display_regs.sv
`timescale 1ns/1ps

module post_display_regs import non_pfr_pkg::*; (
    input  logic       i_sys_clk,
    input  logic       i_sys_clk_reset_sync_n,
    input  axil_req_t  i_axil_req,
    output axil_rsp_t  o_axil_rsp,
    output logic [7:0] o_global_state
);

    logic                   live_q;
    logic [7:0]             global_state_q;

    logic                   wr_accept;
    logic                   wr_hit;
    logic                   bvalid_q;
    logic [1:0]             bresp_q;

    logic                   rd_accept;
    logic                   rd_hit;
    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic [1:0]             rresp_q;

    // Held low through reset so no ready line rises before the block is live
    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_clk_reset_sync_n) begin
            live_q <= 1'b0;
        end else begin
            live_q <= 1'b1;
        end
    end

    //////////////////////////////
    // Write channel
    //////////////////////////////

    // Address and data are taken together, only with no response outstanding
    assign wr_accept = live_q && i_axil_req.awvalid && i_axil_req.wvalid && !bvalid_q;
    assign wr_hit    = (i_axil_req.awaddr == GLOBAL_STATE_ADDR);

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_clk_reset_sync_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_accept) begin
            bvalid_q <= 1'b1;
        end else if (i_axil_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (wr_accept) begin
            bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Only byte lane 0 carries the state; other lanes are ignored
    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_clk_reset_sync_n) begin
            global_state_q <= GLOBAL_STATE_RESET;
        end else if (wr_accept && wr_hit && i_axil_req.wstrb[0]) begin
            global_state_q <= i_axil_req.wdata[7:0];
        end
    end

    //////////////////////////////
    // Read channel
    //////////////////////////////

    assign rd_accept = live_q && i_axil_req.arvalid && !rvalid_q;
    assign rd_hit    = (i_axil_req.araddr == GLOBAL_STATE_ADDR);

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_clk_reset_sync_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (i_axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Unmapped reads return zero
    always_ff @(posedge i_sys_clk) begin
        if (rd_accept) begin
            rdata_q <= rd_hit ? {{(AXIL_DATA_W-8){1'b0}}, global_state_q} : '0;
            rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    //////////////////////////////
    // Response bundle
    //////////////////////////////

    always_comb begin
        o_axil_rsp.awready = wr_accept;
        o_axil_rsp.wready  = wr_accept;
        o_axil_rsp.bvalid  = bvalid_q;
        o_axil_rsp.bresp   = bresp_q;
        o_axil_rsp.arready = live_q && !rvalid_q;
        o_axil_rsp.rvalid  = rvalid_q;
        o_axil_rsp.rdata   = rdata_q;
        o_axil_rsp.rresp   = rresp_q;
    end

    assign o_global_state = global_state_q;

    // A pending write response waits for the master
    a_bvalid_hold : assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_clk_reset_sync_n)
        bvalid_q && !i_axil_req.bready |=> bvalid_q
    ) else $error("bvalid dropped before bready");

    // and its code does not move while it waits
    a_bresp_stable : assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_clk_reset_sync_n)
        bvalid_q && !i_axil_req.bready |=> $stable(bresp_q)
    ) else $error("bresp changed while bvalid was pending");

endmodule

// File: verilog/post_led_mux.sv
`timescale 1ns/1ps

module post_led_mux import non_pfr_pkg::*; (
    input  logic       i_sys_clk,
    input  logic       i_sys_clk_reset_sync_n,
    input  logic       i_debug_mode_n,
    input  post_sel_t  i_post_sel,
    input  logic [7:0] i_global_state,
    input  led_byte_t  i_cc_led,
    output led_byte_t  o_led_control
);

    logic [3:0] nibble;
    seg_glyph_t glyph;
    led_byte_t  led_next;
    led_byte_t  led_q;

    //////////////////////////////
    // Digit selection
    //////////////////////////////

    // First display carries the high digit and wins when both are selected
    assign nibble = i_post_sel.seg1_sel_n ? i_global_state[3:0] : i_global_state[7:4];

    seven_seg_decoder u_seven_seg_decoder (
        .i_nibble ( nibble ),
        .o_glyph  ( glyph  )
    );

    //////////////////////////////
    // Output priority
    //////////////////////////////

    always_comb begin
        // Common core owns the lines unless debug mode claims them
        led_next = i_cc_led;

        if (!i_debug_mode_n) begin
            if (!i_post_sel.seg1_sel_n || !i_post_sel.seg2_sel_n) begin
                // Decimal point in bit 7, always lit
                led_next = {1'b0, glyph};
            end else if (i_post_sel.postled_sel) begin
                led_next = POSTLED_PATTERN;
            end
        end
    end

    // Registered for timing closure toward the pins
    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_clk_reset_sync_n) begin
            led_q <= '0;
        end else begin
            led_q <= led_next;
        end
    end

    assign o_led_control = led_q;

    // Outside debug mode the pins follow the common core one cycle late
    a_cc_passthrough : assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_clk_reset_sync_n)
        i_debug_mode_n |=> (o_led_control == $past(i_cc_led))
    ) else $error("LED byte differs from common core outside debug mode");

endmodule

// File: verilog/non_pfr_led_top.sv
`timescale 1ns/1ps

module non_pfr_led_top import non_pfr_pkg::*; (
    // Clock and reset
    input  logic      i_sys_clk,
    input  logic      i_sys_clk_reset_sync_n,

    // Register access
    input  axil_req_t i_axil_req,
    output axil_rsp_t o_axil_rsp,

    // Debug strap and display selects from the common core
    input  logic      i_debug_mode_n,
    input  post_sel_t i_post_sel,

    // LED lines
    input  led_byte_t i_cc_led,
    output led_byte_t o_led_control,

    // Selects toward the board
    output post_sel_t o_post_sel
);

    logic [7:0] global_state;

    //////////////////////////////
    // Global state register
    //////////////////////////////

    post_display_regs u_post_display_regs (
        .i_sys_clk              ( i_sys_clk              ),
        .i_sys_clk_reset_sync_n ( i_sys_clk_reset_sync_n ),
        .i_axil_req             ( i_axil_req             ),
        .o_axil_rsp             ( o_axil_rsp             ),
        .o_global_state         ( global_state           )
    );

    //////////////////////////////
    // POST code display
    //////////////////////////////

    post_led_mux u_post_led_mux (
        .i_sys_clk              ( i_sys_clk              ),
        .i_sys_clk_reset_sync_n ( i_sys_clk_reset_sync_n ),
        .i_debug_mode_n         ( i_debug_mode_n         ),
        .i_post_sel             ( i_post_sel             ),
        .i_global_state         ( global_state           ),
        .i_cc_led               ( i_cc_led               ),
        .o_led_control          ( o_led_control          )
    );

    // Display selects go out untouched, with no register stage
    assign o_post_sel = i_post_sel;

endmodule

// File: verification/tb_non_pfr_led.sv
`timescale 1ns/1ps

module tb_non_pfr_led import non_pfr_pkg::*; ();

    localparam int CLK_PERIOD    = 4;
    localparam int SEED          = 58340;
    localparam int HS_LIMIT      = 16;
    localparam int MAX_DELAY     = 5;
    localparam int N_PASS        = 200;
    localparam int N_DEBUG       = 40;
    localparam int N_POSTLED     = 40;
    localparam int N_AXI         = 120;
    localparam int OP_COUNT      = N_PASS + 4 * N_DEBUG + N_POSTLED + 2 * N_AXI + 8;
    localparam int CYCLES_PER_OP = 2 * HS_LIMIT + MAX_DELAY;
    localparam int MARGIN        = 100;

    logic      sys_clk;
    logic      sys_clk_reset_sync_n;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      debug_mode_n;
    post_sel_t post_sel;
    led_byte_t cc_led;
    led_byte_t led_control;
    post_sel_t post_sel_out;

    // Copy of the global state kept by the write rule
    logic [7:0] model_state;
    int         mismatches;
    int         other_errors;

    non_pfr_led_top DUT (
        .i_sys_clk              ( sys_clk              ),
        .i_sys_clk_reset_sync_n ( sys_clk_reset_sync_n ),
        .i_axil_req             ( axil_req             ),
        .o_axil_rsp             ( axil_rsp             ),
        .i_debug_mode_n         ( debug_mode_n         ),
        .i_post_sel             ( post_sel             ),
        .i_cc_led               ( cc_led               ),
        .o_led_control          ( led_control          ),
        .o_post_sel             ( post_sel_out         )
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Active low glyphs in bit order gfedcba
    function automatic seg_glyph_t hex_glyph(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h18;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    function automatic led_byte_t expected_led(input logic dbg_n, input post_sel_t sel,
                                               input logic [7:0] state, input led_byte_t cc);
        if (dbg_n) return cc;
        if (!sel.seg1_sel_n) return {1'b0, hex_glyph(state[7:4])};
        if (!sel.seg2_sel_n) return {1'b0, hex_glyph(state[3:0])};
        if (sel.postled_sel) return 8'hF0;
        return cc;
    endfunction

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic tick();
        @(posedge sys_clk);
        #1;
    endtask

    // Drive one cycle of LED inputs and check the registered result a cycle later
    task automatic drive_and_check(input logic dbg_n, input post_sel_t sel, input led_byte_t cc);
        led_byte_t exp_led;
        led_byte_t held_led;
        exp_led      = expected_led(dbg_n, sel, model_state, cc);
        held_led     = led_control;
        debug_mode_n = dbg_n;
        post_sel     = sel;
        cc_led       = cc;
        // Selects reach the board at once while the LED byte waits for the edge
        @(negedge sys_clk);
        if (post_sel_out !== sel) begin
            mismatches++;
            $display("mismatch at %0t: post_sel out got %b expected %b", $time,
                     post_sel_out, sel);
        end
        if (led_control !== held_led) begin
            mismatches++;
            $display("mismatch at %0t: led_control changed to %h before the clock edge",
                     $time, led_control);
        end
        tick();
        if (led_control !== exp_led) begin
            mismatches++;
            $display("mismatch at %0t: led_control got %h expected %h", $time,
                     led_control, exp_led);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bdelay);
        logic [1:0] exp_resp;
        logic       accepted;
        logic       done;
        int         waited;
        exp_resp         = (addr == 4'h0) ? RESP_OKAY : RESP_SLVERR;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        accepted         = 1'b0;
        waited           = 0;
        while (!accepted && waited < HS_LIMIT) begin
            @(negedge sys_clk);
            accepted = axil_rsp.awready && axil_rsp.wready;
            tick();
            waited++;
        end
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        if (!accepted) begin
            other_errors++;
            $display("write to address %h was never accepted", addr);
            return;
        end
        if (addr == 4'h0 && strb[0]) model_state = data[7:0];
        // Master holds off the response for a while
        repeat (bdelay) tick();
        axil_req.bready = 1'b1;
        done            = 1'b0;
        waited          = 0;
        while (!done && waited < HS_LIMIT) begin
            @(negedge sys_clk);
            done = axil_rsp.bvalid;
            if (done && axil_rsp.bresp !== exp_resp) begin
                mismatches++;
                $display("mismatch at %0t: bresp for address %h got %b expected %b", $time,
                         addr, axil_rsp.bresp, exp_resp);
            end
            tick();
            waited++;
        end
        axil_req.bready = 1'b0;
        if (!done) begin
            other_errors++;
            $display("no write response came back for address %h", addr);
        end
    endtask

    task automatic axi_read(input logic [3:0] addr, input int rdelay);
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        logic        accepted;
        logic        done;
        int          waited;
        exp_data         = (addr == 4'h0) ? {24'h0, model_state} : 32'h0;
        exp_resp         = (addr == 4'h0) ? RESP_OKAY : RESP_SLVERR;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        accepted         = 1'b0;
        waited           = 0;
        while (!accepted && waited < HS_LIMIT) begin
            @(negedge sys_clk);
            accepted = axil_rsp.arready;
            tick();
            waited++;
        end
        axil_req.arvalid = 1'b0;
        if (!accepted) begin
            other_errors++;
            $display("read of address %h was never accepted", addr);
            return;
        end
        repeat (rdelay) tick();
        axil_req.rready = 1'b1;
        done            = 1'b0;
        waited          = 0;
        while (!done && waited < HS_LIMIT) begin
            @(negedge sys_clk);
            done = axil_rsp.rvalid;
            if (done && (axil_rsp.rdata !== exp_data || axil_rsp.rresp !== exp_resp)) begin
                mismatches++;
                $display("mismatch at %0t: read of %h got %h/%b expected %h/%b", $time, addr,
                         axil_rsp.rdata, axil_rsp.rresp, exp_data, exp_resp);
            end
            tick();
            waited++;
        end
        axil_req.rready = 1'b0;
        if (!done) begin
            other_errors++;
            $display("no read data came back for address %h", addr);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [7:0] state;
        void'($urandom(SEED));
        mismatches           = 0;
        other_errors         = 0;
        model_state          = 8'hDC;
        axil_req             = '0;
        debug_mode_n         = 1'b1;
        post_sel             = post_sel_t'(3'b110);
        cc_led               = '0;
        sys_clk_reset_sync_n = 1'b0;

        // LED byte and every ready line stay low while reset is held
        repeat (3) begin
            tick();
            if (led_control !== 8'h00 || axil_rsp.awready || axil_rsp.wready
                || axil_rsp.arready || axil_rsp.bvalid || axil_rsp.rvalid) begin
                mismatches++;
                $display("mismatch at %0t: outputs not idle during reset, led_control %h",
                         $time, led_control);
            end
        end
        sys_clk_reset_sync_n = 1'b1;
        tick();
        axi_read(4'h0, 0);

        // Debug mode off
        repeat (N_PASS) begin
            drive_and_check(1'b1, post_sel_t'(3'($urandom())), 8'($urandom()));
        end

        // Digits of a freshly written state with seg1 winning over seg2
        repeat (N_DEBUG) begin
            state = 8'($urandom());
            axi_write(4'h0, {24'($urandom()), state}, 4'($urandom()) | 4'h1,
                      $urandom_range(3, 0));
            drive_and_check(1'b0, post_sel_t'({2'b01, 1'($urandom())}), 8'($urandom()));
            drive_and_check(1'b0, post_sel_t'({2'b10, 1'($urandom())}), 8'($urandom()));
            drive_and_check(1'b0, post_sel_t'({2'b00, 1'($urandom())}), 8'($urandom()));
        end

        // Both digit selects off
        repeat (N_POSTLED) begin
            drive_and_check(1'b0, post_sel_t'({2'b11, 1'($urandom())}), 8'($urandom()));
        end

        // Mixed register traffic while the display shows whatever state is left
        repeat (N_AXI) begin
            if ($urandom_range(1, 0) == 0) begin
                axi_write(($urandom_range(1, 0) == 0) ? 4'h0 : 4'($urandom_range(15, 1)),
                          $urandom(), 4'($urandom()), $urandom_range(MAX_DELAY, 0));
            end else begin
                axi_read(($urandom_range(1, 0) == 0) ? 4'h0 : 4'($urandom_range(15, 1)),
                         $urandom_range(MAX_DELAY, 0));
            end
            drive_and_check(1'($urandom()), post_sel_t'(3'($urandom())), 8'($urandom()));
        end
        axi_read(4'h0, 0);

        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Budget covers the worst handshake and delay for every operation
    initial begin
        #(CLK_PERIOD * (CYCLES_PER_OP * OP_COUNT + MARGIN));
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: list.f
verilog/non_pfr_pkg.sv
verilog/seven_seg_decoder.sv
verilog/post_display_regs.sv
verilog/post_led_mux.sv
verilog/non_pfr_led_top.sv
verification/tb_non_pfr_led.sv

// File: Makefile
TOP := tb_non_pfr_led

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
